/* rtl/pcs_block_pkg.sv */
`default_nettype none

// ------------------------------
// 64b/66b pcs block definitions
// ------------------------------

package pcs_block_pkg;

  // payload bits carried by one 66-bit block
  localparam int payload_width = 64;

  // sync header bits in front of every payload
  localparam int header_width = 2;

  // bit 0 is the earliest bit on the serial line
  typedef logic [payload_width-1:0] payload_t;

  typedef logic [header_width-1:0] header_t;

  // one block as seen on the pma side
  // header packs into the low two bits after the payload
  typedef struct packed {
    payload_t payload;
    header_t  header;
  } pcs_block_t;

  // block plus the framing flag that came with it
  // both are captured on the same edge so they stay paired
  typedef struct packed {
    pcs_block_t block;
    logic       synched;
  } staged_block_t;

  // header of a control block
  // also the header that registers show out of reset
  localparam header_t header_ctrl = 2'b10;

endpackage

`default_nettype wire

/* rtl/descrambler_pkg.sv */
`default_nettype none

// ------------------------------
// descrambler constants and types
// ------------------------------

package descrambler_pkg;

  // self synchronizing polynomial G(x) = 1 + x^39 + x^58
  // the far tap equals the state length
  localparam int state_width = 58;

  // nearer tap counted in bits back from the current bit
  localparam int tap_near = 39;

  // last 58 scrambled bits of the stream
  // bit 0 holds the most recent bit
  typedef logic [state_width-1:0] state_t;

  // all ones start value
  // any non zero seed flushes out after 58 bits anyway
  localparam state_t state_seed_default = '1;

  // operating mode of the datapath
  // hold freezes the output and the state
  // bypass forwards the staged block as it is
  // descramble runs the xor network and advances the state
  typedef enum logic [1:0] {
    mode_hold       = 2'b00,
    mode_bypass     = 2'b01,
    mode_descramble = 2'b10
  } descram_mode_e;

endpackage

`default_nettype wire

/* rtl/block_capture.sv */
`timescale 1ns/10ps
`default_nettype none

// registered input stage
// captures the incoming block and its framing flag on every edge
module block_capture (
  input  wire                           clock,
  input  wire                           reset,
  input  wire pcs_block_pkg::pcs_block_t datain,
  input  wire                           din_synched,
  output pcs_block_pkg::staged_block_t  stage
);

  // ------------------------------
  // reset value of the stage
  // ------------------------------

  // empty control block, not framed
  localparam pcs_block_pkg::staged_block_t stage_reset = '{
    block: '{
      payload: '0,
      header:  pcs_block_pkg::header_ctrl
    },
    synched: 1'b0
  };

  // ------------------------------
  // capture register
  // ------------------------------

  // runs in every mode
  // words presented while the output holds are simply overwritten here
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      stage <= stage_reset;
    end else begin
      // the only place a block and its flag are joined
      stage.block   <= datain;
      stage.synched <= din_synched;
    end
  end

endmodule

`default_nettype wire

/* rtl/descrambler_core.sv */
`timescale 1ns/10ps
`default_nettype none

// 58-bit descrambler state and the 64-bit parallel xor network
// works on one staged payload per clock
module descrambler_core #(
  parameter descrambler_pkg::state_t state_seed = descrambler_pkg::state_seed_default
) (
  input  wire                          clock,
  input  wire                          reset,
  input  wire pcs_block_pkg::payload_t stage_payload,
  input  wire                          advance,
  output pcs_block_pkg::payload_t      plain_payload
);

  // ------------------------------
  // sizes
  // ------------------------------

  localparam int payload_width = pcs_block_pkg::payload_width;
  localparam int state_width   = descrambler_pkg::state_width;
  localparam int tap_near      = descrambler_pkg::tap_near;

  // state bits followed by payload bits, in stream order
  localparam int hist_width = payload_width + state_width;

  // ------------------------------
  // signals
  // ------------------------------

  // scrambled bits seen so far
  // state_q[0] is the last bit of the previous payload
  descrambler_pkg::state_t state_q;

  // value loaded into state_q when the word is consumed
  descrambler_pkg::state_t state_next;

  // scrambled stream laid out by position
  // history[j] is stream bit j - 58 relative to this payload
  // so history[57:0] is the old state and history[121:58] the payload
  logic [hist_width-1:0] history;

  // ------------------------------
  // stream view
  // ------------------------------

  always_comb begin : history_build
    // the state is stored newest first, flip it into stream order
    for (int m = 0; m < state_width; m++) begin
      history[m] = state_q[state_width-1-m];
    end
    history[hist_width-1:state_width] = stage_payload;
  end

  // ------------------------------
  // parallel xor network
  // ------------------------------

  // serial rule out(n) = in(n) ^ in(n-39) ^ in(n-58)
  // unrolled over the whole word in one step
  // bits 0..38 take both taps from the state
  // bits 39..57 take the far tap from the state
  // bits 58..63 use only this payload
  always_comb begin : xor_network
    for (int i = 0; i < payload_width; i++) begin
      plain_payload[i] = history[i+state_width]
                       ^ history[i+state_width-tap_near]
                       ^ history[i];
    end
  end

  // ------------------------------
  // state update
  // ------------------------------

  // keep the last 58 scrambled bits of the word
  // payload bit 63 becomes the newest bit at state bit 0
  // payload bit 6 ends up oldest at state bit 57
  always_comb begin : state_load
    for (int k = 0; k < state_width; k++) begin
      state_next[k] = stage_payload[payload_width-1-k];
    end
  end

  // advance is high only when the word is really descrambled
  // bypass and hold leave the history untouched
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= state_seed;
    end else if (advance) begin
      state_q <= state_next;
    end
  end

endmodule

`default_nettype wire

/* rtl/output_select.sv */
`timescale 1ns/10ps
`default_nettype none

// mode decode and the output block register
module output_select (
  input  wire                             clock,
  input  wire                             reset,
  input  wire pcs_block_pkg::staged_block_t stage,
  input  wire pcs_block_pkg::payload_t    plain_payload,
  input  wire                             descram_enable,
  input  wire                             bypass_enable,
  output logic                            advance,
  output pcs_block_pkg::pcs_block_t       dataout,
  output logic                            dout_synched
);

  // ------------------------------
  // mode decode
  // ------------------------------

  descrambler_pkg::descram_mode_e mode;

  // descram_enable low wins over bypass
  always_comb begin
    if (!descram_enable) begin
      mode = descrambler_pkg::mode_hold;
    end else if (bypass_enable) begin
      mode = descrambler_pkg::mode_bypass;
    end else begin
      mode = descrambler_pkg::mode_descramble;
    end
  end

  // the core consumes the staged word only when descrambling
  assign advance = (mode == descrambler_pkg::mode_descramble);

  // ------------------------------
  // output register
  // ------------------------------

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      dataout.payload <= '0;
      dataout.header  <= pcs_block_pkg::header_ctrl;
    end else begin
      case (mode)
        descrambler_pkg::mode_descramble: begin
          // header is never scrambled
          dataout.payload <= plain_payload;
          dataout.header  <= stage.block.header;
        end
        descrambler_pkg::mode_bypass: begin
          dataout <= stage.block;
        end
        default: begin
          // hold, last word stays on the output
          dataout <= dataout;
        end
      endcase
    end
  end

  // framing flag follows its block through the stage
  // updated in every mode so it stays two cycles behind din_synched
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      dout_synched <= 1'b0;
    end else begin
      dout_synched <= stage.synched;
    end
  end

endmodule

`default_nettype wire

/* rtl/descrambler_parallel.sv */
`timescale 1ns/10ps
`default_nettype none

// 10GBASE-R parallel descrambler, one 66-bit block per clock
// datain to dataout takes two cycles
module descrambler_parallel #(
  parameter descrambler_pkg::state_t state_seed = descrambler_pkg::state_seed_default
) (
  input  wire                           clock,
  input  wire                           reset,
  input  wire pcs_block_pkg::pcs_block_t datain,
  input  wire                           descram_enable,
  input  wire                           bypass_enable,
  input  wire                           din_synched,
  output pcs_block_pkg::pcs_block_t     dataout,
  output logic                          dout_synched
);

  // ------------------------------
  // internal wiring
  // ------------------------------

  // registered block plus framing flag
  pcs_block_pkg::staged_block_t stage;

  // high when the staged word is descrambled this cycle
  logic advance;

  // combinational result of the xor network
  pcs_block_pkg::payload_t plain_payload;

  // first cycle, capture block and flag
  block_capture i_block_capture (
    .clock       (clock),
    .reset       (reset),
    .datain      (datain),
    .din_synched (din_synched),
    .stage       (stage)
  );

  // state register and xor network
  descrambler_core #(
    .state_seed (state_seed)
  ) i_descrambler_core (
    .clock         (clock),
    .reset         (reset),
    .stage_payload (stage.block.payload),
    .advance       (advance),
    .plain_payload (plain_payload)
  );

  // second cycle, pick the result by mode and register it
  output_select i_output_select (
    .clock          (clock),
    .reset          (reset),
    .stage          (stage),
    .plain_payload  (plain_payload),
    .descram_enable (descram_enable),
    .bypass_enable  (bypass_enable),
    .advance        (advance),
    .dataout        (dataout),
    .dout_synched   (dout_synched)
  );

endmodule

`default_nettype wire

/* test/descrambler_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module descrambler_tb;

  // ------------------------------
  // dut signals
  // ------------------------------

  logic                      clock;
  logic                      reset;
  pcs_block_pkg::pcs_block_t datain;
  logic                      descram_enable;
  logic                      bypass_enable;
  logic                      din_synched;
  pcs_block_pkg::pcs_block_t dataout;
  logic                      dout_synched;

  // ------------------------------
  // reference model
  // ------------------------------

  // serial histories of scrambled bits, bit 0 newest
  descrambler_pkg::state_t tx_hist;
  descrambler_pkg::state_t rx_hist;

  // expected output per presented word
  // front entry is due at the next falling edge once two are queued
  pcs_block_pkg::staged_block_t exp_q[$];
  pcs_block_pkg::staged_block_t last_exp;

  // mode that the word now in the dut stage will see
  descrambler_pkg::descram_mode_e staged_mode;

  // din_synched two clocks back
  logic [1:0] synched_delay;

  int    checks;
  int    errors;
  int    test_checks;
  int    test_errors;
  string test_name;

  // output register and stage right after reset
  localparam pcs_block_pkg::staged_block_t reset_exp = '{
    block: '{
      payload: '0,
      header:  pcs_block_pkg::header_ctrl
    },
    synched: 1'b0
  };

  descrambler_parallel i_dut (
    .clock          (clock),
    .reset          (reset),
    .datain         (datain),
    .descram_enable (descram_enable),
    .bypass_enable  (bypass_enable),
    .din_synched    (din_synched),
    .dataout        (dataout),
    .dout_synched   (dout_synched)
  );

  // 20 ns clock
  always #10 clock = ~clock;

  // ------------------------------
  // framing flag latency
  // ------------------------------

  always @(posedge clock or posedge reset) begin
    if (reset) begin
      synched_delay <= 2'b00;
    end else begin
      synched_delay <= {synched_delay[0], din_synched};
    end
  end

  // flag must trail din_synched by two clocks whatever the mode
  flag_latency: assert property (@(posedge clock) disable iff (reset)
    dout_synched == synched_delay[1])
  else begin
    $display("mismatch %s dout_synched latency expected %b actual %b",
             test_name, $sampled(synched_delay[1]), $sampled(dout_synched));
    note_error();
  end

  // ------------------------------
  // serial rules
  // ------------------------------

  // scrambler, s(n) = p(n) ^ s(n-39) ^ s(n-58)
  function automatic pcs_block_pkg::payload_t scramble_serial(
    input pcs_block_pkg::payload_t plain,
    inout descrambler_pkg::state_t hist
  );
    pcs_block_pkg::payload_t scr;
    scr = '0;
    for (int n = 0; n < pcs_block_pkg::payload_width; n++) begin
      scr[n] = plain[n] ^ hist[descrambler_pkg::tap_near-1]
             ^ hist[descrambler_pkg::state_width-1];
      hist = {hist[descrambler_pkg::state_width-2:0], scr[n]};
    end
    return scr;
  endfunction

  // descrambler, p(n) = s(n) ^ s(n-39) ^ s(n-58)
  // history takes the received bit, not the result
  function automatic pcs_block_pkg::payload_t descramble_serial(
    input pcs_block_pkg::payload_t scr,
    inout descrambler_pkg::state_t hist
  );
    pcs_block_pkg::payload_t plain;
    plain = '0;
    for (int n = 0; n < pcs_block_pkg::payload_width; n++) begin
      plain[n] = scr[n] ^ hist[descrambler_pkg::tap_near-1]
               ^ hist[descrambler_pkg::state_width-1];
      hist = {hist[descrambler_pkg::state_width-2:0], scr[n]};
    end
    return plain;
  endfunction

  function automatic pcs_block_pkg::pcs_block_t random_block();
    pcs_block_pkg::pcs_block_t block;
    block.payload = {$urandom(), $urandom()};
    // any header value, 00 and 11 included
    block.header = pcs_block_pkg::header_t'($urandom());
    return block;
  endfunction

  function automatic descrambler_pkg::descram_mode_e random_mode();
    descrambler_pkg::descram_mode_e mode;
    case ($urandom_range(2, 0))
      0: mode = descrambler_pkg::mode_hold;
      1: mode = descrambler_pkg::mode_bypass;
      default: mode = descrambler_pkg::mode_descramble;
    endcase
    return mode;
  endfunction

  // ------------------------------
  // checking
  // ------------------------------

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic abort_run(input string reason);
    $display("timeout: %s", reason);
    $display("Checks failed");
    $finish;
  endtask

  task automatic check_block(input pcs_block_pkg::pcs_block_t exp);
    checks++;
    test_checks++;
    assert (dataout === exp) else begin
      $display("mismatch %s dataout expected %h actual %h", test_name, exp, dataout);
      note_error();
    end
  endtask

  task automatic check_flag(input logic exp);
    checks++;
    test_checks++;
    assert (dout_synched === exp) else begin
      $display("mismatch %s dout_synched expected %b actual %b", test_name, exp, dout_synched);
      note_error();
    end
  endtask

  // word presented two falling edges ago is on the outputs now
  task automatic check_output();
    pcs_block_pkg::staged_block_t exp;
    if (exp_q.size() >= 2) begin
      exp = exp_q.pop_front();
      check_block(exp.block);
      check_flag(exp.synched);
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  // clock should fall within a few of its own transitions
  task automatic wait_falling_edge();
    int edges;
    edges = 0;
    do begin
      @(clock);
      edges++;
    end while (clock !== 1'b0 && edges < 3);
    if (clock !== 1'b0) begin
      abort_run("no falling clock edge");
    end
  endtask

  // in hold the bypass input is random, descram_enable low must win
  task automatic drive_enables(input descrambler_pkg::descram_mode_e mode);
    case (mode)
      descrambler_pkg::mode_descramble: begin
        descram_enable = 1'b1;
        bypass_enable  = 1'b0;
      end
      descrambler_pkg::mode_bypass: begin
        descram_enable = 1'b1;
        bypass_enable  = 1'b1;
      end
      default: begin
        descram_enable = 1'b0;
        bypass_enable  = 1'($urandom());
      end
    endcase
  endtask

  // new word goes out together with the enables for the staged one
  task automatic present_word(
    input pcs_block_pkg::pcs_block_t      block,
    input logic                           synched,
    input descrambler_pkg::descram_mode_e mode
  );
    pcs_block_pkg::staged_block_t exp;
    wait_falling_edge();
    check_output();
    datain      = block;
    din_synched = synched;
    drive_enables(staged_mode);
    staged_mode = mode;
    case (mode)
      descrambler_pkg::mode_descramble: begin
        exp.block.payload = descramble_serial(block.payload, rx_hist);
        exp.block.header  = block.header;
      end
      descrambler_pkg::mode_bypass: begin
        exp.block = block;
      end
      default: begin
        // output register keeps the previous word
        exp.block = last_exp.block;
      end
    endcase
    exp.synched = synched;
    last_exp    = exp;
    exp_q.push_back(exp);
  endtask

  // plaintext through the tb scrambler, then descrambled by the dut
  task automatic send_plain();
    pcs_block_pkg::pcs_block_t block;
    pcs_block_pkg::payload_t   plain;
    block = random_block();
    plain = block.payload;
    block.payload = scramble_serial(plain, tx_hist);
    present_word(block, 1'b1, descrambler_pkg::mode_descramble);
  endtask

  // two held words push the last real words out to the checker
  task automatic drain_pipeline();
    repeat (2) begin
      present_word(random_block(), 1'($urandom()), descrambler_pkg::mode_hold);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic finish_test();
    $display("test %s finished, %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    void'($urandom(32'h598e_80ba));
    clock          = 1'b0;
    reset          = 1'b1;
    datain         = reset_exp.block;
    descram_enable = 1'b0;
    bypass_enable  = 1'b0;
    din_synched    = 1'b0;
    checks         = 0;
    errors         = 0;
    tx_hist        = descrambler_pkg::state_seed_default;
    rx_hist        = descrambler_pkg::state_seed_default;
    last_exp       = reset_exp;
    staged_mode    = descrambler_pkg::mode_hold;

    start_test("reset_values");
    #2;
    check_block(reset_exp.block);
    check_flag(1'b0);
    repeat (4) begin
      wait_falling_edge();
      check_block(reset_exp.block);
      check_flag(1'b0);
    end
    reset = 1'b0;
    // the reset stage word is held on the first edges
    exp_q.push_back(reset_exp);
    finish_test();

    start_test("descramble_round_trip");
    repeat (40) send_plain();
    drain_pipeline();
    finish_test();

    // bypassed words must not reach the history
    start_test("bypass");
    repeat (4) send_plain();
    repeat (8) present_word(random_block(), 1'b1, descrambler_pkg::mode_bypass);
    repeat (12) send_plain();
    drain_pipeline();
    finish_test();

    // words presented in hold are dropped
    start_test("hold");
    repeat (4) send_plain();
    repeat (6) present_word(random_block(), 1'b1, descrambler_pkg::mode_hold);
    repeat (12) send_plain();
    drain_pipeline();
    finish_test();

    start_test("framing_flag");
    repeat (40) present_word(random_block(), 1'($urandom()), random_mode());
    drain_pipeline();
    finish_test();

    $display("total %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* descrambler_parallel.f */
rtl/pcs_block_pkg.sv
rtl/descrambler_pkg.sv
rtl/block_capture.sv
rtl/descrambler_core.sv
rtl/output_select.sv
rtl/descrambler_parallel.sv
test/descrambler_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the descrambler testbench with verilator and run it
# run from the project root
# exit status is non zero on a build error or a reported failure

top=descrambler_tb
log=sim.log

rm -rf obj_dir "$log"

# compile, then run, everything goes to the log
verilator --binary --timing --assert \
  -f descrambler_parallel.f \
  --top-module "$top" \
  -o "$top" > "$log" 2>&1 &&
  ./obj_dir/"$top" >> "$log" 2>&1 ||
  {
    cat "$log"
    echo "build or simulation did not complete"
    exit 1
  }

cat "$log"

# the testbench prints its fail line on any error or timeout
grep -q "Checks failed" "$log" &&
  { echo "simulation failed"; exit 1; } ||
  { echo "simulation passed"; exit 0; }
